// ==== Makefile ====
BIN  := obj_dir/Vtb_event_intake
SRCS := $(wildcard source/*.sv source/*.svh tb/*.sv)

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

$(BIN): $(SRCS) flist.f
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f flist.f --top-module tb_event_intake

clean:
	rm -rf obj_dir

// ==== flist.f ====
+incdir+source
source/event_pkg.sv
source/link_bus_if.sv
source/link_intake.sv
source/dword_stat_counter.sv
source/start_event_gen.sv
source/event_regs.sv
source/event_intake_top.sv
tb/tb_event_intake.sv

// ==== source/dword_stat_counter.sv ====
`timescale 1ns/1ps
`include "event_params.svh"

module dword_stat_counter (
    input  logic                   aclk,
    input  logic                   reset_i,
    input  logic                   soft_reset_i,
    input  event_pkg::link_mask_t   raw_valid_i,
    output event_pkg::dword_count_t count_o [`EV_NUM_LINKS]
);
    import event_pkg::*;

    ////////////////////////////////////////
    // per-link dword counts
    ////////////////////////////////////////

    dword_count_t count_q [`EV_NUM_LINKS];
    logic         clear;

    // either reset empties every count
    assign clear = reset_i | soft_reset_i;

    for (genvar i = 0; i < `EV_NUM_LINKS; i++) begin : g_count
        always_ff @(posedge aclk) begin
            if (clear) begin
                count_q[i] <= '0;
            end else if (raw_valid_i[i]) begin
                // counts raw valid, ready is ignored
                count_q[i] <= count_q[i] + dword_count_t'(1);
            end
        end

        assign count_o[i] = count_q[i];
    end

endmodule

// ==== source/event_intake_top.sv ====
`timescale 1ns/1ps
`include "event_params.svh"

module event_intake_top (
    input  logic                                 aclk,
    input  logic                                 reset_i,
    input  logic                                 event_open_i,
    // raw link inputs, link n in dword n
    input  logic [`EV_NUM_LINKS*`EV_LINK_DW-1:0] s_link_tdata_i,
    input  event_pkg::link_mask_t                 s_link_tvalid_i,
    input  event_pkg::link_mask_t                 s_link_tlast_i,
    output event_pkg::link_mask_t                 s_link_tready_o,
    // gated link outputs
    output logic [`EV_NUM_LINKS*`EV_LINK_DW-1:0] m_link_tdata_o,
    output event_pkg::link_mask_t                 m_link_tvalid_o,
    output event_pkg::link_mask_t                 m_link_tlast_o,
    input  event_pkg::link_mask_t                 m_link_tready_i,
    output logic                                 start_event_o,
    // register bus
    input  logic                                 wb_cyc_i,
    input  logic                                 wb_stb_i,
    input  logic                                 wb_we_i,
    input  event_pkg::wb_addr_t                   wb_adr_i,
    input  event_pkg::wb_data_t                   wb_dat_i,
    input  logic [3:0]                           wb_sel_i,
    output logic                                 wb_ack_o,
    output event_pkg::wb_data_t                   wb_dat_o
);
    import event_pkg::*;

    link_data_t   s_tdata [`EV_NUM_LINKS];
    dword_count_t count [`EV_NUM_LINKS];
    logic         soft_reset;
    link_mask_t   link_mask;

    link_bus_if link ();

    ////////////////////////////////////////
    // port packing
    ////////////////////////////////////////

    for (genvar i = 0; i < `EV_NUM_LINKS; i++) begin : g_pack
        assign s_tdata[i] = s_link_tdata_i[i*`EV_LINK_DW +: `EV_LINK_DW];
        assign m_link_tdata_o[i*`EV_LINK_DW +: `EV_LINK_DW] = link.tdata[i];
    end

    // downstream side of the link bus
    assign m_link_tvalid_o = link.tvalid;
    assign m_link_tlast_o  = link.tlast;
    assign link.tready     = m_link_tready_i;

    ////////////////////////////////////////
    // blocks
    ////////////////////////////////////////

    link_intake u_intake (
        .aclk         (aclk),
        .reset_i      (reset_i),
        .event_open_i (event_open_i),
        .s_tdata_i    (s_tdata),
        .s_tvalid_i   (s_link_tvalid_i),
        .s_tlast_i    (s_link_tlast_i),
        .s_tready_o   (s_link_tready_o),
        .link         (link.producer)
    );

    // statistics watch the raw valids
    dword_stat_counter u_stats (
        .aclk         (aclk),
        .reset_i      (reset_i),
        .soft_reset_i (soft_reset),
        .raw_valid_i  (s_link_tvalid_i),
        .count_o      (count)
    );

    start_event_gen u_start (
        .aclk          (aclk),
        .reset_i       (reset_i),
        .soft_reset_i  (soft_reset),
        .link_mask_i   (link_mask),
        .link          (link.monitor),
        .start_event_o (start_event_o)
    );

    event_regs u_regs (
        .aclk         (aclk),
        .reset_i      (reset_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_sel_i     (wb_sel_i),
        .wb_ack_o     (wb_ack_o),
        .wb_dat_o     (wb_dat_o),
        .count_i      (count),
        .soft_reset_o (soft_reset),
        .link_mask_o  (link_mask)
    );

endmodule

// ==== source/event_params.svh ====
`ifndef EVENT_PARAMS_SVH
`define EVENT_PARAMS_SVH

////////////////////////////////////////
// link streams
////////////////////////////////////////

// number of incoming links
`define EV_NUM_LINKS 4
// one link dword
`define EV_LINK_DW 32

////////////////////////////////////////
// register bus
////////////////////////////////////////

`define EV_WB_AW 15
`define EV_WB_DW 32
// register slot select, 16 slots above the byte offset
`define EV_REG_SEL_LSB 2
`define EV_REG_SEL_W 4

`endif

// ==== source/event_pkg.sv ====
`include "event_params.svh"

package event_pkg;

    ////////////////////////////////////////
    // link side types
    ////////////////////////////////////////

    // one dword on a link stream
    typedef logic [`EV_LINK_DW-1:0] link_data_t;

    // one flag per link: mask, valids, readies, lasts
    typedef logic [`EV_NUM_LINKS-1:0] link_mask_t;

    // dword statistics count, wraps
    typedef logic [31:0] dword_count_t;

    ////////////////////////////////////////
    // register bus types
    ////////////////////////////////////////

    typedef logic [`EV_WB_AW-1:0] wb_addr_t;

    typedef logic [`EV_WB_DW-1:0] wb_data_t;

    // register slot within the 16-slot map
    typedef logic [`EV_REG_SEL_W-1:0] reg_sel_t;

endpackage

// ==== source/event_regs.sv ====
`timescale 1ns/1ps
`include "event_params.svh"

module event_regs (
    input  logic                   aclk,
    input  logic                   reset_i,
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  event_pkg::wb_addr_t     wb_adr_i,
    input  event_pkg::wb_data_t     wb_dat_i,
    input  logic [3:0]             wb_sel_i,
    output logic                   wb_ack_o,
    output event_pkg::wb_data_t     wb_dat_o,
    input  event_pkg::dword_count_t count_i [`EV_NUM_LINKS],
    output logic                   soft_reset_o,
    output event_pkg::link_mask_t   link_mask_o
);
    import event_pkg::*;

    reg_sel_t   reg_sel;
    wb_data_t   ctrl_word;
    wb_data_t   rd_mux;
    wb_data_t   dat_q;
    logic       ack_q;
    logic       req;
    logic       soft_reset_q;
    link_mask_t link_mask_q;

    assign req     = wb_cyc_i & wb_stb_i;
    assign reg_sel = wb_adr_i[`EV_REG_SEL_LSB +: `EV_REG_SEL_W];

    ////////////////////////////////////////
    // read decode
    ////////////////////////////////////////

    // reset in bit 0, mask in bits 8..11
    always_comb begin
        ctrl_word = '0;
        ctrl_word[0] = soft_reset_q;
        ctrl_word[8 +: `EV_NUM_LINKS] = link_mask_q;
    end

    // bit 3 of the select is ignored, upper half mirrors lower
    always_comb begin
        if (!reg_sel[2]) begin
            rd_mux = ctrl_word;
        end else begin
            rd_mux = count_i[reg_sel[1:0]];
        end
    end

    ////////////////////////////////////////
    // bus handshake and writes
    ////////////////////////////////////////

    always_ff @(posedge aclk) begin
        // sample on the first cycle of a read
        if (req && !wb_we_i && !ack_q) begin
            dat_q <= rd_mux;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset_i) begin
            ack_q        <= 1'b0;
            soft_reset_q <= 1'b0;
            link_mask_q  <= '0;
        end else begin
            ack_q <= req;
            // writes land in the ack cycle, any slot
            if (req && wb_ack_o && wb_we_i) begin
                if (wb_sel_i[0]) begin
                    soft_reset_q <= wb_dat_i[0];
                end
                if (wb_sel_i[1]) begin
                    link_mask_q <= wb_dat_i[8 +: `EV_NUM_LINKS];
                end
            end
        end
    end

    assign wb_ack_o     = ack_q & wb_cyc_i;
    assign wb_dat_o     = dat_q;
    assign soft_reset_o = soft_reset_q;
    assign link_mask_o  = link_mask_q;

    // every ack answers a strobe seen one cycle earlier
    a_ack_follows_req : assert property (
        @(posedge aclk) disable iff (reset_i)
        wb_ack_o |-> $past(wb_cyc_i && wb_stb_i)
    );

endmodule

// ==== source/link_bus_if.sv ====
`timescale 1ns/1ps
`include "event_params.svh"

interface link_bus_if;
    import event_pkg::*;

    // gated link streams, one set per link
    link_data_t tdata [`EV_NUM_LINKS];
    link_mask_t tvalid;
    link_mask_t tready;
    link_mask_t tlast;

    // gate side
    modport producer (
        output tdata,
        output tvalid,
        output tlast,
        input  tready
    );

    // downstream sink
    modport consumer (
        input  tdata,
        input  tvalid,
        input  tlast,
        output tready
    );

    // passive watcher
    modport monitor (
        input tdata,
        input tvalid,
        input tlast,
        input tready
    );

endinterface

// ==== source/link_intake.sv ====
`timescale 1ns/1ps
`include "event_params.svh"

module link_intake (
    input  logic                aclk,
    input  logic                reset_i,
    input  logic                event_open_i,
    input  event_pkg::link_data_t s_tdata_i [`EV_NUM_LINKS],
    input  event_pkg::link_mask_t s_tvalid_i,
    input  event_pkg::link_mask_t s_tlast_i,
    output event_pkg::link_mask_t s_tready_o,
    link_bus_if.producer        link
);

    ////////////////////////////////////////
    // event window
    ////////////////////////////////////////

    // sampled once, follows the input one cycle later
    logic open_q;

    always_ff @(posedge aclk) begin
        open_q <= event_open_i;
    end

    ////////////////////////////////////////
    // per-link gate
    ////////////////////////////////////////

    for (genvar i = 0; i < `EV_NUM_LINKS; i++) begin : g_gate
        // payload passes untouched
        assign link.tdata[i] = s_tdata_i[i];
        assign link.tlast[i] = s_tlast_i[i];

        // closed window: hide the beat downstream
        assign link.tvalid[i] = s_tvalid_i[i] & open_q;

        // closed window: accept and drop everything
        assign s_tready_o[i] = link.tready[i] | ~open_q;
    end

    // a beat only reaches the link bus if the window was open a cycle earlier
    a_no_valid_closed : assert property (
        @(posedge aclk) disable iff (reset_i)
        !$past(event_open_i) |-> (link.tvalid == '0)
    );

endmodule

// ==== source/start_event_gen.sv ====
`timescale 1ns/1ps
`include "event_params.svh"

module start_event_gen (
    input  logic                 aclk,
    input  logic                 reset_i,
    input  logic                 soft_reset_i,
    input  event_pkg::link_mask_t link_mask_i,
    link_bus_if.monitor          link,
    output logic                 start_event_o
);
    import event_pkg::*;

    link_mask_t hs_last;
    link_mask_t last_hs_q;
    link_mask_t unmasked;
    link_mask_t first_unmasked;
    logic       start_q;

    // last beat accepted on each link this cycle
    assign hs_last = link.tlast & link.tvalid & link.tready;

    ////////////////////////////////////////
    // stage 1: capture header ends
    ////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (reset_i || soft_reset_i) begin
            last_hs_q <= '0;
        end else begin
            last_hs_q <= hs_last;
        end
    end

    ////////////////////////////////////////
    // stage 2: lowest unmasked link wins
    ////////////////////////////////////////

    // isolate lowest set bit, zero when all masked
    assign unmasked       = ~link_mask_i;
    assign first_unmasked = unmasked & (~unmasked + link_mask_t'(1));

    always_ff @(posedge aclk) begin
        if (reset_i || soft_reset_i) begin
            start_q <= 1'b0;
        end else begin
            start_q <= |(last_hs_q & first_unmasked);
        end
    end

    assign start_event_o = start_q;

    // a pulse traces back to a last beat two cycles earlier on the selected link
    a_start_has_cause : assert property (
        @(posedge aclk) disable iff (reset_i)
        start_event_o |-> |($past(hs_last, 2) & $past(first_unmasked))
    );

endmodule

// ==== tb/tb_event_intake.sv ====
`timescale 1ns/1ps
`include "event_params.svh"

module tb_event_intake;

    localparam int NL             = `EV_NUM_LINKS;
    localparam int CTRL_OPS       = 24;
    localparam int ROUNDS         = 5;
    localparam int ROUND_CYCLES   = 200;
    localparam int HOLD_CYCLES    = 20;
    // each traffic burst adds one idle cycle and two quiet cycles
    localparam int TRAFFIC_CYCLES = ROUNDS * (ROUND_CYCLES + 3) + HOLD_CYCLES + 3 + 10;
    localparam int BUS_OPS        = 3 * CTRL_OPS + ROUNDS * 9 + 2 + 4;
    localparam int WATCHDOG_NS    = (TRAFFIC_CYCLES + BUS_OPS) * 20;

    logic                     aclk;
    logic                     reset;
    logic                     event_open;
    logic [NL*`EV_LINK_DW-1:0] s_tdata;
    logic [NL-1:0]            s_tvalid;
    logic [NL-1:0]            s_tlast;
    logic [NL-1:0]            s_tready;
    logic [NL*`EV_LINK_DW-1:0] m_tdata;
    logic [NL-1:0]            m_tvalid;
    logic [NL-1:0]            m_tlast;
    logic [NL-1:0]            m_tready;
    logic                     start_event;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    logic [`EV_WB_AW-1:0]     wb_adr;
    logic [`EV_WB_DW-1:0]     wb_dat;
    logic [3:0]               wb_sel;
    logic                     wb_ack;
    logic [`EV_WB_DW-1:0]     wb_dat_rd;

    // reference model state
    logic [31:0]   lfsr_state = 32'h4d6aa780;
    logic          open_m;
    logic          soft_m;
    logic [NL-1:0] mask_m;
    logic [NL-1:0] hs_now;
    logic [NL-1:0] hs_q;
    logic          start_exp;
    logic [31:0]   cnt_m [NL];
    logic          checking;
    int            gate_errs;
    int            start_errs;
    int            reg_errs;

    event_intake_top uut (
        .aclk            (aclk),
        .reset_i         (reset),
        .event_open_i    (event_open),
        .s_link_tdata_i  (s_tdata),
        .s_link_tvalid_i (s_tvalid),
        .s_link_tlast_i  (s_tlast),
        .s_link_tready_o (s_tready),
        .m_link_tdata_o  (m_tdata),
        .m_link_tvalid_o (m_tvalid),
        .m_link_tlast_o  (m_tlast),
        .m_link_tready_i (m_tready),
        .start_event_o   (start_event),
        .wb_cyc_i        (wb_cyc),
        .wb_stb_i        (wb_stb),
        .wb_we_i         (wb_we),
        .wb_adr_i        (wb_adr),
        .wb_dat_i        (wb_dat),
        .wb_sel_i        (wb_sel),
        .wb_ack_o        (wb_ack),
        .wb_dat_o        (wb_dat_rd)
    );

    always #2 aclk = ~aclk;

    ////////////////////////////////////////
    // random source
    ////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    ////////////////////////////////////////
    // model helpers
    ////////////////////////////////////////

    // one-hot of the lowest link whose mask bit is clear
    function automatic logic [NL-1:0] lowest_unmasked(input logic [NL-1:0] mask);
        logic [NL-1:0] sel;
        sel = '0;
        for (int i = NL - 1; i >= 0; i--) begin
            if (!mask[i]) begin
                sel = '0;
                sel[i] = 1'b1;
            end
        end
        return sel;
    endfunction

    function automatic logic [31:0] ctrl_expect();
        return {20'h0, mask_m, 7'h0, soft_m};
    endfunction

    // upper and byte address bits are not decoded, so fill them randomly
    function automatic logic [`EV_WB_AW-1:0] bus_addr(input logic [3:0] slot);
        logic [8:0] hi;
        logic [1:0] lo;
        hi = 9'(take_bits(9));
        lo = 2'(take_bits(2));
        return {hi, slot, lo};
    endfunction

    // counts, start pipeline and window lag, all on the clock edge
    always @(posedge aclk) begin
        hs_now = s_tlast & s_tvalid & m_tready & {NL{open_m}};
        if (reset || soft_m) begin
            hs_q      <= '0;
            start_exp <= 1'b0;
        end else begin
            hs_q      <= hs_now;
            start_exp <= |(hs_q & lowest_unmasked(mask_m));
        end
        for (int i = 0; i < NL; i++) begin
            if (reset || soft_m) begin
                cnt_m[i] <= '0;
            end else if (s_tvalid[i]) begin
                cnt_m[i] <= cnt_m[i] + 32'd1;
            end
        end
        open_m <= event_open;
    end

    ////////////////////////////////////////
    // per-cycle checks
    ////////////////////////////////////////

    always @(negedge aclk) begin
        if (checking) begin
            if (m_tvalid !== (s_tvalid & {NL{open_m}})) begin
                gate_errs++;
                $display("Error %0t: gated valid %h, expected %h", $time, m_tvalid,
                         s_tvalid & {NL{open_m}});
            end
            if (s_tready !== (open_m ? m_tready : {NL{1'b1}})) begin
                gate_errs++;
                $display("Error %0t: raw ready %h with open %b", $time, s_tready, open_m);
            end
            if (m_tdata !== s_tdata || m_tlast !== s_tlast) begin
                gate_errs++;
                $display("Error %0t: data or last not passed through", $time);
            end
            if (start_event !== start_exp) begin
                start_errs++;
                $display("Error %0t: start event %b, expected %b", $time, start_event,
                         start_exp);
            end
        end
    end

    ////////////////////////////////////////
    // bus and traffic tasks
    ////////////////////////////////////////

    task automatic wait_ack();
        @(negedge aclk);
        while (wb_ack !== 1'b1) begin
            @(negedge aclk);
        end
    endtask

    task automatic bus_write(input logic [3:0] slot, input logic [31:0] data,
                             input logic [3:0] sel);
        @(posedge aclk);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b1;
        wb_adr = bus_addr(slot);
        wb_dat = data;
        wb_sel = sel;
        wait_ack();
        // the register takes the write on this edge
        @(posedge aclk);
        #1;
        if (sel[0]) begin
            soft_m = data[0];
        end
        if (sel[1]) begin
            mask_m = data[8 +: NL];
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic read_check(input logic [3:0] slot, input logic [31:0] exp,
                              input string what);
        @(posedge aclk);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_sel = 4'hf;
        wb_adr = bus_addr(slot);
        wait_ack();
        if (wb_dat_rd !== exp) begin
            reg_errs++;
            $display("Error %0t: slot %0d %s read %h, expected %h", $time, slot, what,
                     wb_dat_rd, exp);
        end
        @(posedge aclk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic run_traffic(input int cycles);
        logic [NL-1:0] r;
        for (int c = 0; c < cycles; c++) begin
            @(posedge aclk);
            #1;
            event_open = (take_bits(2) != 0);
            s_tvalid   = NL'(take_bits(NL));
            s_tlast    = NL'(take_bits(NL));
            r          = NL'(take_bits(NL));
            m_tready   = r | NL'(take_bits(NL));
            for (int i = 0; i < NL; i++) begin
                s_tdata[i*`EV_LINK_DW +: `EV_LINK_DW] = take_bits(32);
            end
        end
        @(posedge aclk);
        #1;
        s_tvalid = '0;
        s_tlast  = '0;
        // let the counts settle before any read
        repeat (2) @(posedge aclk);
    endtask

    task automatic run_round(input logic [NL-1:0] mask);
        bus_write(4'(take_bits(4)), {20'h0, mask, 8'h0}, 4'hf);
        run_traffic(ROUND_CYCLES);
        for (int i = 0; i < NL; i++) begin
            read_check(4'(4 + i), cnt_m[i], "count");
            read_check(4'(12 + i), cnt_m[i], "mirrored count");
        end
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        aclk       = 1'b0;
        reset      = 1'b1;
        event_open = 1'b0;
        s_tdata    = '0;
        s_tvalid   = '0;
        s_tlast    = '0;
        m_tready   = '0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat     = '0;
        wb_sel     = '0;
        open_m     = 1'b0;
        soft_m     = 1'b0;
        mask_m     = '0;
        hs_q       = '0;
        start_exp  = 1'b0;
        checking   = 1'b0;
        gate_errs  = 0;
        start_errs = 0;
        reg_errs   = 0;
        for (int i = 0; i < NL; i++) begin
            cnt_m[i] = '0;
        end
        repeat (3) @(posedge aclk);
        #1;
        reset    = 1'b0;
        checking = 1'b1;

        // control word with random byte selects, direct and mirrored
        for (int k = 0; k < CTRL_OPS; k++) begin
            bus_write(4'(take_bits(4)), take_bits(32), 4'(take_bits(4)));
            read_check(4'd0, ctrl_expect(), "control");
            read_check(4'd8, ctrl_expect(), "mirrored control");
        end

        // traffic rounds, one of them fully masked
        run_round(4'h0);
        run_round(NL'(take_bits(NL)));
        run_round(4'hf);
        run_round(NL'(take_bits(NL)));

        // soft reset held over some traffic, then released
        bus_write(4'(take_bits(4)), 32'h1, 4'b0001);
        run_traffic(HOLD_CYCLES);
        bus_write(4'(take_bits(4)), 32'h0, 4'b0001);
        for (int i = 0; i < NL; i++) begin
            read_check(4'(4 + i), 32'h0, "count after soft reset");
        end
        run_round(NL'(take_bits(NL)));

        $display("error counts: %0d gating, %0d start, %0d register",
                 gate_errs, start_errs, reg_errs);
        if (gate_errs + start_errs + reg_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the test sequence did not finish, a bus ack may be missing");
        $display("TB FAILED");
        $finish;
    end

endmodule
